//--- all.f
+incdir+rtl
rtl/bch_pkg.sv
rtl/bch_stream_if.sv
rtl/bch_enc.sv
rtl/bch_syndrome_chk.sv
rtl/bch_codec_top.sv
verification/bch_tb.sv

//--- rtl/bch_codec_top.sv
//------------------------------
// bch codec datapath top
// encoder -> link -> checker
//------------------------------

`timescale 1ns/1ps

module bch_codec_top (
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  // source stream
  input  logic isop,
  input  logic ieop,
  input  logic ieof,
  input  logic ival,
  input  logic idat,
  // link corruption
  input  logic iflip,
  // checked stream
  output logic osop,
  output logic oeop,
  output logic oval,
  output logic odat,
  output logic odone,
  output logic oerr
);

  //------------------------------
  // encoder to checker link
  //------------------------------

  bch_stream_if link ();

  // +1 cycle, payload then parity
  bch_enc bch_enc_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .link    (link.source),
    .isop    (isop),
    .ieop    (ieop),
    .ieof    (ieof),
    .ival    (ival),
    .idat    (idat)
  );

  // +1 cycle, flip then syndrome
  bch_syndrome_chk bch_syndrome_chk_inst (
    .iclk    (iclk),
    .ireset  (ireset),
    .iclkena (iclkena),
    .link    (link.sink),
    .iflip   (iflip),
    .osop    (osop),
    .oeop    (oeop),
    .oval    (oval),
    .odat    (odat),
    .odone   (odone),
    .oerr    (oerr)
  );

endmodule

//--- rtl/bch_enc.sv
//------------------------------
// systematic bch lfsr encoder
// payload passes, parity follows
//------------------------------

`timescale 1ns/1ps

`include "bch_params.svh"

module bch_enc (
  input  logic         iclk,
  input  logic         ireset,
  input  logic         iclkena,
  bch_stream_if.source link,
  input  logic         isop,    // first payload bit
  input  logic         ieop,    // last payload bit
  input  logic         ieof,    // last codeword slot
  input  logic         ival,
  input  logic         idat
);

  import bch_pkg::*;

  //------------------------------
  // declarations
  //------------------------------

  localparam gpoly_t GPOLY = `BCH_GPOLY;

  enc_phase_t phase;
  remainder_t state;
  remainder_t state_base;   // state seen by this bit
  remainder_t state_next;
  logic       pass;         // payload bit in this cycle
  logic       fb;           // division feedback

  //------------------------------
  // lfsr next state
  //------------------------------

  assign pass       = isop | (phase == PH_DATA);  // sop bit always payload
  assign state_base = isop ? '0 : state;          // fresh division per frame

  // zero feedback in code phase just shifts the remainder out
  assign fb = pass ? (idat ^ state_base[`BCH_R-1]) : 1'b0;

  always_comb begin
    state_next[0] = GPOLY[0] & fb;
    for (int i = 1; i < `BCH_R; i++) begin
      state_next[i] = (GPOLY[i] & fb) ^ state_base[i-1];
    end
  end

  //------------------------------
  // control and flags
  //------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      phase    <= PH_DATA;
      state    <= '0;
      link.val <= 1'b0;
      link.sop <= 1'b0;
      link.eop <= 1'b0;
      link.eof <= 1'b0;
    end else if (iclkena) begin
      link.val <= ival;
      link.sop <= isop;
      link.eop <= ieof;   // packet ends at codeword end
      link.eof <= ieof;
      if (ival) begin
        if (isop) begin
          phase <= PH_DATA;
        end else if (ieop) begin
          phase <= PH_CODE;  // parity from next bit on
        end
        state <= state_next;
      end
    end
  end

  //------------------------------
  // serial data out
  //------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && ival) begin
      // payload as is, else remainder msb first
      link.dat <= pass ? idat : state_base[`BCH_R-1];
    end
  end

endmodule

//--- rtl/bch_params.svh
//------------------------------
// bch(15,5,7) code constants
// lengths and generator polynomial
//------------------------------

`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

//------------------------------
// code geometry
//------------------------------

`define BCH_N 15                  // codeword bits
`define BCH_K 5                   // payload bits
`define BCH_R (`BCH_N - `BCH_K)   // parity bits, 10

//------------------------------
// generator polynomial
//------------------------------

// g(x) = x^10 + x^8 + x^5 + x^4 + x^2 + x + 1
// bit 10 is implicit in the lfsr, low 10 bits are the taps
`define BCH_GPOLY 11'h537

`endif

//--- rtl/bch_pkg.sv
//------------------------------
// bch codec shared types
//------------------------------

`include "bch_params.svh"

package bch_pkg;

  //------------------------------
  // vector types
  //------------------------------

  typedef logic [`BCH_R:0]   gpoly_t;      // full g(x), msb is x^10
  typedef logic [`BCH_R-1:0] remainder_t;  // lfsr state, enc and chk

  //------------------------------
  // phase enums
  //------------------------------

  // encoder: passing payload or shifting parity out
  typedef enum logic {
    PH_DATA = 1'b0,
    PH_CODE = 1'b1
  } enc_phase_t;

  // checker: between frames or inside one
  typedef enum logic {
    CK_IDLE  = 1'b0,
    CK_FRAME = 1'b1
  } chk_phase_t;

endpackage

//--- rtl/bch_stream_if.sv
//------------------------------
// bit-serial frame stream
// between encoder and checker
//------------------------------

`timescale 1ns/1ps

interface bch_stream_if;

  logic sop;  // first codeword bit
  logic eop;  // packet end, mirrored out
  logic eof;  // codeword end, closes the syndrome
  logic val;  // bit qualifier
  logic dat;  // serial codeword bit

  // producer side
  modport source (
    output sop,
    output eop,
    output eof,
    output val,
    output dat
  );

  // consumer side
  modport sink (
    input sop,
    input eop,
    input eof,
    input val,
    input dat
  );

endinterface

//--- rtl/bch_syndrome_chk.sv
//------------------------------
// bch syndrome checker
// flags nonzero remainder at eof
//------------------------------

`timescale 1ns/1ps

`include "bch_params.svh"

module bch_syndrome_chk (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  bch_stream_if.sink link,
  input  logic       iflip,   // corrupt this link bit
  output logic       osop,
  output logic       oeop,
  output logic       oval,
  output logic       odat,
  output logic       odone,   // frame checked
  output logic       oerr     // valid with odone
);

  import bch_pkg::*;

  //------------------------------
  // declarations
  //------------------------------

  localparam gpoly_t GPOLY = `BCH_GPOLY;

  chk_phase_t phase;
  remainder_t rem;
  remainder_t rem_base;
  remainder_t rem_next;
  logic       din;      // link bit after flip
  logic       fb;
  logic       done;

  //------------------------------
  // divider r = r*x + din mod g
  //------------------------------

  assign din      = link.dat ^ (iflip & link.val);  // flip only valid bits
  assign rem_base = link.sop ? '0 : rem;            // sop starts a new frame
  assign fb       = rem_base[`BCH_R-1];             // x^10 term to reduce

  assign rem_next = {rem_base[`BCH_R-2:0], din} ^ (GPOLY[`BCH_R-1:0] & {`BCH_R{fb}});

  // closing bit of a frame in progress
  assign done = link.val & link.eof & (phase == CK_FRAME);

  //------------------------------
  // frame tracking and flags
  //------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      phase <= CK_IDLE;
      rem   <= '0;
      osop  <= 1'b0;
      oeop  <= 1'b0;
      oval  <= 1'b0;
      odone <= 1'b0;
      oerr  <= 1'b0;
    end else if (iclkena) begin
      osop  <= link.sop;
      oeop  <= link.eop;
      oval  <= link.val;
      odone <= done;             // single pulse with oeop
      if (done) begin
        oerr <= |rem_next;       // includes the eof bit
      end
      if (link.val) begin
        rem <= rem_next;
        if (link.eof) begin
          phase <= CK_IDLE;
        end else if (link.sop) begin
          phase <= CK_FRAME;
        end
      end
    end
  end

  //------------------------------
  // mirrored data
  //------------------------------

  always_ff @(posedge iclk) begin
    if (iclkena && link.val) begin
      odat <= din;  // shows the bit as checked
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the bch codec testbench with verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f all.f --top-module bch_tb -o bch_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/bch_sim > "$SIM_LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status, see $SIM_LOG"
fi

if grep -q "^=== PASS ===$" "$SIM_LOG"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $SIM_LOG"
exit 1

//--- verification/bch_tb.sv
//------------------------------
// bch codec testbench
// random frames, flips, stalls
//------------------------------

`timescale 1ns/1ps

`include "bch_params.svh"

module bch_tb;

  localparam int NUM_FRAMES = 300;
  localparam int MAX_CYCLES = 15000;   // 300 frames of up to 40 cycles plus margin

  logic iclk;
  logic ireset;
  logic iclkena;
  logic isop, ieop, ieof, ival, idat;
  logic iflip;
  logic osop, oeop, oval, odat, odone, oerr;

  logic [3:0] exp_q[$];       // {sop, eof, dat, err} per output bit
  logic       link_flip = 1'b0;  // flip owed to the bit now on the link
  logic       fresh = 1'b0;      // outputs moved at the last edge
  int         cycles = 0;
  logic [31:0] rnd;

  bch_codec_top bch_codec_top_inst (
    .iclk(iclk), .ireset(ireset), .iclkena(iclkena),
    .isop(isop), .ieop(ieop), .ieof(ieof), .ival(ival), .idat(idat),
    .iflip(iflip),
    .osop(osop), .oeop(oeop), .oval(oval), .odat(odat),
    .odone(odone), .oerr(oerr)
  );

  initial begin
    iclk = 1'b0;
    forever #20 iclk = ~iclk;
  end

  //------------------------------
  // reference and checks
  //------------------------------

  // msg * x^10 mod g(x) msb first
  function automatic logic [`BCH_N-1:0] ref_encode(input logic [`BCH_K-1:0] msg);
    logic [`BCH_N-1:0] rem;
    logic [`BCH_N-1:0] g_ext;
    g_ext = '0;
    g_ext[`BCH_R:0] = `BCH_GPOLY;
    rem = {msg, {`BCH_R{1'b0}}};
    for (int i = `BCH_N - 1; i >= `BCH_R; i--) begin
      if (rem[i]) rem = rem ^ (g_ext << (i - `BCH_R));  // cancel the leading term
    end
    return {msg, rem[`BCH_R-1:0]};
  endfunction

  task automatic fail_run(input string what);
    $display("%s at %0t", what, $time);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input int actual);
    if (expected !== actual) begin
      $display("Fail t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1);
    end
  endtask

  task automatic compare_outputs();
    logic [3:0] exp;
    if (oval) begin
      if (exp_q.size() == 0) begin
        fail_run("output bit seen with no matching input bit");
      end else begin
        exp = exp_q.pop_front();
        check_value("osop", int'(exp[3]), int'(osop));
        check_value("oeop", int'(exp[2]), int'(oeop));
        check_value("odone", int'(exp[2]), int'(odone));  // pulses with oeop
        check_value("odat", int'(exp[1]), int'(odat));
        if (exp[2]) begin
          check_value("oerr", int'(exp[0]), int'(oerr));
        end
      end
    end else begin
      check_value("osop", 0, int'(osop));   // no flags between bits
      check_value("oeop", 0, int'(oeop));
      check_value("odone", 0, int'(odone));
    end
  endtask

  // outputs read at the edge hold what the previous enabled edge wrote
  always @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      fresh <= 1'b0;
    end else begin
      if (fresh) compare_outputs();
      fresh <= iclkena;
    end
  end

  always @(posedge iclk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) fail_run("run timed out before all frames were checked");
  end

  //------------------------------
  // stimulus
  //------------------------------

  task automatic drive_cycle(input logic ena, input logic val, input logic sop,
                             input logic eop, input logic eof, input logic dat,
                             input logic flip);
    @(negedge iclk);
    iflip   = link_flip;     // flip hits the bit one enabled cycle later
    iclkena = ena;
    ival    = val;
    isop    = sop;
    ieop    = eop;
    ieof    = eof;
    idat    = dat;
    if (ena) link_flip = val & flip;
  endtask

  task automatic send_frame(input logic [`BCH_K-1:0] msg, input int flip_pos);
    logic [`BCH_N-1:0] cw;
    logic              bit_in;
    logic              flip;
    int                b;
    cw = ref_encode(msg);
    b  = 0;
    while (b < `BCH_N) begin
      rnd = $urandom;
      if (rnd[2:0] == 3'd0) begin
        drive_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, rnd[8], 1'b0);  // stall
      end else if (rnd[5:3] == 3'd0) begin
        drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, rnd[8], 1'b0);  // gap
      end else begin
        // parity slots carry junk the encoder ignores
        bit_in = (b < `BCH_K) ? cw[`BCH_N - 1 - b] : rnd[9];
        flip   = (b == flip_pos);
        drive_cycle(1'b1, 1'b1, b == 0, b == `BCH_K - 1, b == `BCH_N - 1, bit_in, flip);
        exp_q.push_back({b == 0, b == `BCH_N - 1, cw[`BCH_N - 1 - b] ^ flip,
                         flip_pos >= 0});
        b++;
      end
    end
  endtask

  initial begin
    logic [`BCH_K-1:0] msg;
    int                pos;
    rnd     = $urandom(32'h05471e9e);
    ireset  = 1'b1;
    iclkena = 1'b0;
    isop    = 1'b0;
    ieop    = 1'b0;
    ieof    = 1'b0;
    ival    = 1'b0;
    idat    = 1'b0;
    iflip   = 1'b0;
    repeat (10) @(negedge iclk);
    ireset = 1'b0;

    // corner messages clean and with one flip
    send_frame('0, -1);
    send_frame('1, -1);
    send_frame('0, 3);
    send_frame('1, 14);
    for (int f = 4; f < NUM_FRAMES; f++) begin
      rnd = $urandom;
      msg = rnd[`BCH_K-1:0];
      pos = rnd[8] ? int'(rnd[19:16]) % `BCH_N : -1;
      send_frame(msg, pos);
    end

    // flush the pipe then watch for stray bits
    while (exp_q.size() != 0) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (4) drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);

    $display("=== PASS ===");
    $finish;
  end

endmodule
